//--- rtl/csr_pkg.sv
package csr_pkg;

  // Widths that carry a meaning across the issue path.
  typedef logic [7:0]  phys_tag_t;  // Physical register tag.
  typedef logic [31:0] inst_num_t;  // ROB sequence number.
  typedef logic [31:0] word_t;
  typedef logic [11:0] csr_addr_t;

  // Encoding follows funct3[1:0] of the Zicsr instructions.
  typedef enum logic [1:0] {
    CSR_RW = 2'b01,  // Write source.
    CSR_RS = 2'b10,  // Set source bits.
    CSR_RC = 2'b11   // Clear source bits.
  } csr_op_t;

  // Machine-mode CSRs implemented by the unit.
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;

  // mstatus bit positions.
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

endpackage

//--- rtl/csr_wakeup.sv
`timescale 1ns/100ps

module csr_wakeup #(
  parameter int DEPTH = 8
) (
  input  csr_pkg::phys_tag_t [DEPTH-1:0] entry_tags,
  input  csr_pkg::phys_tag_t             dispatch_tag,
  input  logic                           alu_done,
  input  csr_pkg::phys_tag_t             alu_tag,
  input  logic                           mul_done,
  input  csr_pkg::phys_tag_t             mul_tag,
  input  logic                           div_done,
  input  csr_pkg::phys_tag_t             div_tag,
  input  logic                           mem_read,
  input  csr_pkg::phys_tag_t             mem_tag,
  input  logic                           br_done,
  input  csr_pkg::phys_tag_t             br_tag,
  input  logic                           p_done,
  input  csr_pkg::phys_tag_t             p_tag,
  input  logic                           csr_done,
  input  csr_pkg::phys_tag_t             csr_tag,
  output logic [DEPTH-1:0]               wake,
  output logic                           dispatch_wake
);

  localparam int NUM_SRC = 7;

  logic [NUM_SRC-1:0] bc_valid;
  csr_pkg::phys_tag_t bc_tag [NUM_SRC];

  // mem_tag only counts during a load.
  assign bc_valid = {csr_done, p_done, br_done, mem_read, div_done, mul_done, alu_done};

  assign bc_tag[0] = alu_tag;
  assign bc_tag[1] = mul_tag;
  assign bc_tag[2] = div_tag;
  assign bc_tag[3] = mem_tag;
  assign bc_tag[4] = br_tag;
  assign bc_tag[5] = p_tag;
  assign bc_tag[6] = csr_tag;

  always_comb begin
    wake          = '0;
    dispatch_wake = 1'b0;
    for (int s = 0; s < NUM_SRC; s++) begin
      if (bc_valid[s]) begin
        for (int e = 0; e < DEPTH; e++) begin
          if (entry_tags[e] == bc_tag[s]) begin
            wake[e] = 1'b1;
          end
        end
        if (dispatch_tag == bc_tag[s]) begin
          dispatch_wake = 1'b1;  // Producer finishing at dispatch.
        end
      end
    end
  end

endmodule

//--- rtl/csr_rs.sv
`timescale 1ns/100ps

module csr_rs #(
  parameter int DEPTH = 8
) (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           flush,
  input  logic                           dispatch,
  input  csr_pkg::inst_num_t             inst_num,
  input  csr_pkg::phys_tag_t             rd_tag,
  input  csr_pkg::phys_tag_t             src_tag,
  input  csr_pkg::csr_op_t               csr_op,
  input  csr_pkg::csr_addr_t             csr_addr,
  input  logic                           use_imm,
  input  csr_pkg::word_t                 imm,
  input  logic                           src_ready,
  input  logic [DEPTH-1:0]               wake,
  input  logic                           dispatch_wake,
  output csr_pkg::phys_tag_t [DEPTH-1:0] entry_tags,
  output logic                           rs_full,
  output logic                           issue_valid,
  output csr_pkg::inst_num_t             issue_inst_num,
  output csr_pkg::phys_tag_t             issue_rd_tag,
  output csr_pkg::phys_tag_t             issue_src_tag,
  output csr_pkg::csr_op_t               issue_op,
  output csr_pkg::csr_addr_t             issue_addr,
  output logic                           issue_use_imm,
  output csr_pkg::word_t                 issue_imm
);

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Entry control state.
  logic [DEPTH-1:0] valid;
  logic [DEPTH-1:0] ready;

  // Entry payload.
  csr_pkg::inst_num_t inst_nums [DEPTH];
  csr_pkg::phys_tag_t rd_tags   [DEPTH];
  csr_pkg::csr_op_t   ops       [DEPTH];
  csr_pkg::csr_addr_t addrs     [DEPTH];
  logic               use_imms  [DEPTH];
  csr_pkg::word_t     imms      [DEPTH];

  logic [IDX_W-1:0] alloc_idx;
  logic [IDX_W-1:0] issue_idx;
  logic [DEPTH-1:0] issue_req;
  logic             do_alloc;
  logic             dispatch_ready;

  assign rs_full = &valid;

  // Rename holds off while full; a stray dispatch is dropped.
  assign do_alloc = dispatch & ~rs_full & ~flush;

  // Immediate form has no register source to wait for.
  assign dispatch_ready = use_imm | src_ready | dispatch_wake;

  // Lowest free slot.
  always_comb begin
    alloc_idx = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        alloc_idx = IDX_W'(i);
      end
    end
  end

  assign issue_req   = valid & ready;
  assign issue_valid = |issue_req;

  // Lowest ready slot wins.
  always_comb begin
    issue_idx = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (issue_req[i]) begin
        issue_idx = IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid <= '0;
      ready <= '0;
    end else if (flush) begin
      valid <= '0;
      ready <= '0;
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        if (valid[i] && wake[i]) begin
          ready[i] <= 1'b1;
        end
      end
      if (issue_valid) begin
        valid[issue_idx] <= 1'b0;  // Slot frees as it issues.
      end
      // Alloc and issue never hit the same slot.
      if (do_alloc) begin
        valid[alloc_idx] <= 1'b1;
        ready[alloc_idx] <= dispatch_ready;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_alloc) begin
      inst_nums[alloc_idx]  <= inst_num;
      rd_tags[alloc_idx]    <= rd_tag;
      entry_tags[alloc_idx] <= src_tag;
      ops[alloc_idx]        <= csr_op;
      addrs[alloc_idx]      <= csr_addr;
      use_imms[alloc_idx]   <= use_imm;
      imms[alloc_idx]       <= imm;
    end
  end

  assign issue_inst_num = inst_nums[issue_idx];
  assign issue_rd_tag   = rd_tags[issue_idx];
  assign issue_src_tag  = entry_tags[issue_idx];
  assign issue_op       = ops[issue_idx];
  assign issue_addr     = addrs[issue_idx];
  assign issue_use_imm  = use_imms[issue_idx];
  assign issue_imm      = imms[issue_idx];

endmodule

//--- rtl/csr_unit.sv
`timescale 1ns/100ps

module csr_unit (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               flush,
  input  logic               trap,
  input  csr_pkg::word_t     trap_pc,
  input  csr_pkg::word_t     trap_cause,
  input  logic               mret,
  input  logic               issue_valid,
  input  csr_pkg::inst_num_t issue_inst_num,
  input  csr_pkg::phys_tag_t issue_rd_tag,
  input  csr_pkg::phys_tag_t issue_src_tag,
  input  csr_pkg::csr_op_t   issue_op,
  input  csr_pkg::csr_addr_t issue_addr,
  input  logic               issue_use_imm,
  input  csr_pkg::word_t     issue_imm,
  input  csr_pkg::word_t     prf_rdata,
  output csr_pkg::phys_tag_t prf_raddr,
  output logic               csr_done,
  output csr_pkg::phys_tag_t done_tag,
  output csr_pkg::inst_num_t done_inst_num,
  output csr_pkg::word_t     done_value,
  output csr_pkg::word_t     trap_vector,
  output csr_pkg::word_t     epc
);

  // Issue register.
  logic               iss_valid;
  csr_pkg::inst_num_t iss_inst_num;
  csr_pkg::phys_tag_t iss_rd_tag;
  csr_pkg::phys_tag_t iss_src_tag;
  csr_pkg::csr_op_t   iss_op;
  csr_pkg::csr_addr_t iss_addr;
  logic               iss_use_imm;
  csr_pkg::word_t     iss_imm;

  // CSR file.
  csr_pkg::word_t mstatus;
  csr_pkg::word_t mtvec;
  csr_pkg::word_t mscratch;
  csr_pkg::word_t mepc;
  csr_pkg::word_t mcause;

  csr_pkg::word_t src_val;
  csr_pkg::word_t old_val;
  csr_pkg::word_t new_val;
  logic           wr_en;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      iss_valid <= 1'b0;
    end else begin
      iss_valid <= issue_valid & ~flush;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      iss_inst_num <= issue_inst_num;
      iss_rd_tag   <= issue_rd_tag;
      iss_src_tag  <= issue_src_tag;
      iss_op       <= issue_op;
      iss_addr     <= issue_addr;
      iss_use_imm  <= issue_use_imm;
      iss_imm      <= issue_imm;
    end
  end

  // Register file answers in the same cycle.
  assign prf_raddr = iss_src_tag;
  assign src_val   = iss_use_imm ? iss_imm : prf_rdata;

  always_comb begin
    case (iss_addr)
      csr_pkg::CSR_MSTATUS:  old_val = mstatus;
      csr_pkg::CSR_MTVEC:    old_val = mtvec;
      csr_pkg::CSR_MSCRATCH: old_val = mscratch;
      csr_pkg::CSR_MEPC:     old_val = mepc;
      csr_pkg::CSR_MCAUSE:   old_val = mcause;
      default:               old_val = '0;  // Unimplemented.
    endcase
  end

  always_comb begin
    case (iss_op)
      csr_pkg::CSR_RW: new_val = src_val;
      csr_pkg::CSR_RS: new_val = old_val | src_val;
      csr_pkg::CSR_RC: new_val = old_val & ~src_val;
      default:         new_val = old_val;
    endcase
  end

  // A flushed instruction neither writes nor completes.
  assign wr_en = iss_valid & ~flush;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mstatus  <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
    end else if (trap) begin
      mepc                          <= trap_pc;
      mcause                        <= trap_cause;
      mstatus[csr_pkg::MSTATUS_MPIE] <= mstatus[csr_pkg::MSTATUS_MIE];
      mstatus[csr_pkg::MSTATUS_MIE]  <= 1'b0;
    end else if (mret) begin
      mstatus[csr_pkg::MSTATUS_MIE]  <= mstatus[csr_pkg::MSTATUS_MPIE];
      mstatus[csr_pkg::MSTATUS_MPIE] <= 1'b1;
    end else if (wr_en) begin
      case (iss_addr)
        csr_pkg::CSR_MSTATUS:  mstatus  <= new_val;
        csr_pkg::CSR_MTVEC:    mtvec    <= {new_val[31:2], 2'b00};  // Direct mode only.
        csr_pkg::CSR_MSCRATCH: mscratch <= new_val;
        csr_pkg::CSR_MEPC:     mepc     <= new_val;
        csr_pkg::CSR_MCAUSE:   mcause   <= new_val;
        default:               ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      csr_done <= 1'b0;
    end else begin
      csr_done <= wr_en;
    end
  end

  // rd receives the value before the write.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      done_tag      <= iss_rd_tag;
      done_inst_num <= iss_inst_num;
      done_value    <= old_val;
    end
  end

  assign trap_vector = mtvec;
  assign epc         = mepc;

endmodule

//--- rtl/csr_issue_top.sv
`timescale 1ns/100ps

module csr_issue_top #(
  parameter int DEPTH = 8
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               dispatch,
  input  csr_pkg::inst_num_t inst_num,
  input  csr_pkg::phys_tag_t rd_tag,
  input  csr_pkg::csr_op_t   csr_op,
  input  csr_pkg::csr_addr_t csr_addr,
  input  logic               use_imm,
  input  csr_pkg::word_t     imm,
  input  csr_pkg::phys_tag_t src_tag,
  input  logic               src_ready,
  input  logic               alu_done,
  input  csr_pkg::phys_tag_t alu_tag,
  input  logic               mul_done,
  input  csr_pkg::phys_tag_t mul_tag,
  input  logic               div_done,
  input  csr_pkg::phys_tag_t div_tag,
  input  logic               br_done,
  input  csr_pkg::phys_tag_t br_tag,
  input  logic               p_done,
  input  csr_pkg::phys_tag_t p_tag,
  input  logic               mem_read,
  input  csr_pkg::phys_tag_t mem_tag,
  input  logic               flush,
  input  logic               trap,
  input  csr_pkg::word_t     trap_pc,
  input  csr_pkg::word_t     trap_cause,
  input  logic               mret,
  output csr_pkg::phys_tag_t prf_raddr,
  input  csr_pkg::word_t     prf_rdata,
  output logic               rs_full,
  output logic               csr_done,
  output csr_pkg::phys_tag_t done_tag,
  output csr_pkg::inst_num_t done_inst_num,
  output csr_pkg::word_t     done_value,
  output csr_pkg::word_t     trap_vector,
  output csr_pkg::word_t     epc
);

  csr_pkg::phys_tag_t [DEPTH-1:0] entry_tags;
  logic [DEPTH-1:0]               wake;
  logic                           dispatch_wake;
  logic                           rs_flush;

  logic               issue_valid;
  csr_pkg::inst_num_t issue_inst_num;
  csr_pkg::phys_tag_t issue_rd_tag;
  csr_pkg::phys_tag_t issue_src_tag;
  csr_pkg::csr_op_t   issue_op;
  csr_pkg::csr_addr_t issue_addr;
  logic               issue_use_imm;
  csr_pkg::word_t     issue_imm;

  assign rs_flush = flush | trap | mret;  // Redirects empty the pipe.

  csr_rs #(.DEPTH(DEPTH)) u_rs (
    .clk            (clk),
    .arst_n         (arst_n),
    .flush          (rs_flush),
    .dispatch       (dispatch),
    .inst_num       (inst_num),
    .rd_tag         (rd_tag),
    .src_tag        (src_tag),
    .csr_op         (csr_op),
    .csr_addr       (csr_addr),
    .use_imm        (use_imm),
    .imm            (imm),
    .src_ready      (src_ready),
    .wake           (wake),
    .dispatch_wake  (dispatch_wake),
    .entry_tags     (entry_tags),
    .rs_full        (rs_full),
    .issue_valid    (issue_valid),
    .issue_inst_num (issue_inst_num),
    .issue_rd_tag   (issue_rd_tag),
    .issue_src_tag  (issue_src_tag),
    .issue_op       (issue_op),
    .issue_addr     (issue_addr),
    .issue_use_imm  (issue_use_imm),
    .issue_imm      (issue_imm)
  );

  // CSR completion is the seventh wakeup source.
  csr_wakeup #(.DEPTH(DEPTH)) u_wakeup (
    .entry_tags    (entry_tags),
    .dispatch_tag  (src_tag),
    .alu_done      (alu_done),
    .alu_tag       (alu_tag),
    .mul_done      (mul_done),
    .mul_tag       (mul_tag),
    .div_done      (div_done),
    .div_tag       (div_tag),
    .mem_read      (mem_read),
    .mem_tag       (mem_tag),
    .br_done       (br_done),
    .br_tag        (br_tag),
    .p_done        (p_done),
    .p_tag         (p_tag),
    .csr_done      (csr_done),
    .csr_tag       (done_tag),
    .wake          (wake),
    .dispatch_wake (dispatch_wake)
  );

  csr_unit u_unit (
    .clk            (clk),
    .arst_n         (arst_n),
    .flush          (rs_flush),
    .trap           (trap),
    .trap_pc        (trap_pc),
    .trap_cause     (trap_cause),
    .mret           (mret),
    .issue_valid    (issue_valid),
    .issue_inst_num (issue_inst_num),
    .issue_rd_tag   (issue_rd_tag),
    .issue_src_tag  (issue_src_tag),
    .issue_op       (issue_op),
    .issue_addr     (issue_addr),
    .issue_use_imm  (issue_use_imm),
    .issue_imm      (issue_imm),
    .prf_rdata      (prf_rdata),
    .prf_raddr      (prf_raddr),
    .csr_done       (csr_done),
    .done_tag       (done_tag),
    .done_inst_num  (done_inst_num),
    .done_value     (done_value),
    .trap_vector    (trap_vector),
    .epc            (epc)
  );

endmodule

//--- verif/csr_issue_tb.sv
`timescale 1ns/100ps

module csr_issue_tb;

  localparam int DEPTH   = 8;
  localparam int TIMEOUT = 2000;

  logic               clk;
  logic               arst_n;
  logic               dispatch;
  csr_pkg::inst_num_t inst_num;
  csr_pkg::phys_tag_t rd_tag;
  csr_pkg::csr_op_t   csr_op;
  csr_pkg::csr_addr_t csr_addr;
  logic               use_imm;
  csr_pkg::word_t     imm;
  csr_pkg::phys_tag_t src_tag;
  logic               src_ready;
  logic [5:0]         bc_done;       // alu, mul, div, mem_read, br, p.
  csr_pkg::phys_tag_t bc_tags [6];
  logic               flush;
  logic               trap;
  logic               mret;
  csr_pkg::word_t     trap_pc;
  csr_pkg::word_t     trap_cause;
  csr_pkg::phys_tag_t prf_raddr;
  csr_pkg::word_t     prf_rdata;
  logic               rs_full;
  logic               csr_done;
  csr_pkg::phys_tag_t done_tag;
  csr_pkg::inst_num_t done_inst_num;
  csr_pkg::word_t     done_value;
  csr_pkg::word_t     trap_vector;
  csr_pkg::word_t     epc;

  csr_pkg::word_t     prf_mem [256];
  csr_pkg::word_t     ref_csr [5];   // mstatus, mtvec, mscratch, mepc, mcause.
  int                 errors;
  int                 cycle_cnt;
  csr_pkg::inst_num_t next_inum;

  assign prf_rdata = prf_mem[prf_raddr];

  always #2 clk = ~clk;

  csr_issue_top #(.DEPTH(DEPTH)) u_dut (
    .clk (clk), .arst_n (arst_n), .dispatch (dispatch), .inst_num (inst_num),
    .rd_tag (rd_tag), .csr_op (csr_op), .csr_addr (csr_addr), .use_imm (use_imm),
    .imm (imm), .src_tag (src_tag), .src_ready (src_ready),
    .alu_done (bc_done[0]), .alu_tag (bc_tags[0]), .mul_done (bc_done[1]), .mul_tag (bc_tags[1]),
    .div_done (bc_done[2]), .div_tag (bc_tags[2]), .mem_read (bc_done[3]), .mem_tag (bc_tags[3]),
    .br_done (bc_done[4]), .br_tag (bc_tags[4]), .p_done (bc_done[5]), .p_tag (bc_tags[5]),
    .flush (flush), .trap (trap), .trap_pc (trap_pc), .trap_cause (trap_cause), .mret (mret),
    .prf_raddr (prf_raddr), .prf_rdata (prf_rdata), .rs_full (rs_full), .csr_done (csr_done),
    .done_tag (done_tag), .done_inst_num (done_inst_num), .done_value (done_value),
    .trap_vector (trap_vector), .epc (epc)
  );

  function automatic int csr_index(csr_pkg::csr_addr_t addr);
    case (addr)
      csr_pkg::CSR_MSTATUS:  return 0;
      csr_pkg::CSR_MTVEC:    return 1;
      csr_pkg::CSR_MSCRATCH: return 2;
      csr_pkg::CSR_MEPC:     return 3;
      csr_pkg::CSR_MCAUSE:   return 4;
      default:               return -1;
    endcase
  endfunction

  function automatic csr_pkg::csr_op_t pick_op(int k);
    case (k)
      0:       return csr_pkg::CSR_RW;
      1:       return csr_pkg::CSR_RS;
      default: return csr_pkg::CSR_RC;
    endcase
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("Error: %s %s expected %h actual %h", test, what, exp, act);
    end
  endtask

  // Reference read-modify-write of the CSR file.
  task automatic model_access(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_op_t op,
                              input csr_pkg::word_t src, output csr_pkg::word_t old);
    int             idx;
    csr_pkg::word_t nv;
    idx = csr_index(addr);
    old = (idx < 0) ? 32'h0 : ref_csr[idx];
    case (op)
      csr_pkg::CSR_RW: nv = src;
      csr_pkg::CSR_RS: nv = old | src;
      default:         nv = old & ~src;
    endcase
    if (idx == 1) nv[1:0] = 2'b00;
    if (idx >= 0) ref_csr[idx] = nv;
  endtask

  task automatic send(input csr_pkg::csr_op_t op, input csr_pkg::csr_addr_t addr,
                      input logic uimm, input csr_pkg::word_t immv,
                      input csr_pkg::phys_tag_t stag, input logic sready,
                      input csr_pkg::phys_tag_t rd, output csr_pkg::inst_num_t inum);
    inum      = next_inum;
    next_inum = next_inum + 1;
    dispatch  = 1'b1;
    inst_num  = inum;
    rd_tag    = rd;
    csr_op    = op;
    csr_addr  = addr;
    use_imm   = uimm;
    imm       = immv;
    src_tag   = stag;
    src_ready = sready;
    step();
    dispatch  = 1'b0;
    src_ready = 1'b0;
  endtask

  // Counts edges until csr_done, then compares the completion with the model.
  task automatic wait_and_check(input string test, input int exp_n,
                                input csr_pkg::csr_op_t op, input csr_pkg::csr_addr_t addr,
                                input logic uimm, input csr_pkg::word_t immv,
                                input csr_pkg::phys_tag_t stag, input csr_pkg::phys_tag_t rd,
                                input csr_pkg::inst_num_t inum);
    int             n;
    csr_pkg::word_t old;
    n = 0;
    while (!csr_done && n < 20) begin
      step();
      n++;
    end
    assert (csr_done) else begin
      errors++;
      $display("%s: no completion within 20 cycles", test);
    end
    model_access(addr, op, uimm ? immv : prf_mem[stag], old);
    check_value(test, "latency", exp_n, n);
    check_value(test, "done_tag", rd, done_tag);
    check_value(test, "done_inst_num", inum, done_inst_num);
    check_value(test, "done_value", old, done_value);
  endtask

  task automatic run_csr(input string test, input csr_pkg::csr_op_t op,
                         input csr_pkg::csr_addr_t addr, input logic uimm,
                         input csr_pkg::word_t immv, input csr_pkg::phys_tag_t stag);
    csr_pkg::phys_tag_t rd;
    csr_pkg::inst_num_t inum;
    rd = csr_pkg::phys_tag_t'($urandom_range(0, 127));
    send(op, addr, uimm, immv, stag, 1'b1, rd, inum);
    wait_and_check(test, 2, op, addr, uimm, immv, stag, rd, inum);
    step();
  endtask

  task automatic expect_idle(input string test, input int cycles);
    repeat (cycles) begin
      assert (!csr_done) else begin
        errors++;
        $display("%s: completion seen while nothing should complete", test);
      end
      step();
    end
  endtask

  task automatic pulse_source(input int s, input csr_pkg::phys_tag_t tag);
    bc_done[s] = 1'b1;
    bc_tags[s] = tag;
    step();
    bc_done[s] = 1'b0;
    bc_tags[s] = '0;
  endtask

  task automatic test_ready_dispatch();
    run_csr("ready_dispatch", csr_pkg::CSR_RW, csr_pkg::CSR_MSCRATCH, 1'b0, '0,
            csr_pkg::phys_tag_t'($urandom_range(0, 255)));
    run_csr("ready_dispatch", csr_pkg::CSR_RS, csr_pkg::CSR_MSCRATCH, 1'b1, '0, '0);
  endtask

  task automatic test_wakeup();
    csr_pkg::phys_tag_t tag;
    csr_pkg::phys_tag_t rd;
    csr_pkg::phys_tag_t rd_b;
    csr_pkg::inst_num_t inum;
    csr_pkg::inst_num_t inum_b;
    string              name;
    for (int s = 0; s < 7; s++) begin
      name = $sformatf("wakeup_src%0d", s);
      tag  = csr_pkg::phys_tag_t'($urandom_range(128, 255));
      rd   = csr_pkg::phys_tag_t'($urandom_range(0, 127));
      send(csr_pkg::CSR_RW, csr_pkg::CSR_MSCRATCH, 1'b0, '0, tag, 1'b0, rd, inum);
      expect_idle(name, 3);
      if (s < 6) begin
        pulse_source(s, tag);
        wait_and_check(name, 2, csr_pkg::CSR_RW, csr_pkg::CSR_MSCRATCH, 1'b0, '0, tag, rd, inum);
      end else begin
        // A CSR instruction that writes the awaited tag.
        rd_b = tag;
        send(csr_pkg::CSR_RS, csr_pkg::CSR_MSCRATCH, 1'b1, '0, '0, 1'b0, rd_b, inum_b);
        wait_and_check(name, 2, csr_pkg::CSR_RS, csr_pkg::CSR_MSCRATCH, 1'b1, '0, '0,
                       rd_b, inum_b);
        step();
        wait_and_check(name, 2, csr_pkg::CSR_RW, csr_pkg::CSR_MSCRATCH, 1'b0, '0, tag, rd, inum);
      end
      step();
    end
    tag = csr_pkg::phys_tag_t'($urandom_range(128, 255));
    rd  = csr_pkg::phys_tag_t'($urandom_range(0, 127));
    send(csr_pkg::CSR_RW, csr_pkg::CSR_MEPC, 1'b0, '0, tag, 1'b0, rd, inum);
    bc_tags[3] = tag;  // Tag without mem_read.
    step();
    bc_tags[3] = '0;
    expect_idle("wakeup_mem_idle", 3);
    pulse_source(3, tag);
    wait_and_check("wakeup_mem_idle", 2, csr_pkg::CSR_RW, csr_pkg::CSR_MEPC, 1'b0, '0,
                   tag, rd, inum);
    step();
    tag        = csr_pkg::phys_tag_t'($urandom_range(128, 255));
    bc_done[0] = 1'b1;
    bc_tags[0] = tag;
    send(csr_pkg::CSR_RW, csr_pkg::CSR_MCAUSE, 1'b0, '0, tag, 1'b0, rd, inum);
    bc_done[0] = 1'b0;
    bc_tags[0] = '0;
    wait_and_check("wakeup_same_cycle", 2, csr_pkg::CSR_RW, csr_pkg::CSR_MCAUSE, 1'b0, '0,
                   tag, rd, inum);
    step();
  endtask

  task automatic test_op_variants();
    csr_pkg::csr_addr_t addrs [6];
    addrs = '{csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MTVEC, csr_pkg::CSR_MSCRATCH,
              csr_pkg::CSR_MEPC, csr_pkg::CSR_MCAUSE, 12'h7c0};
    repeat (30) begin
      run_csr("op_variants", pick_op($urandom_range(0, 2)), addrs[$urandom_range(0, 5)],
              1'($urandom_range(0, 1)), csr_pkg::word_t'($urandom_range(0, 31)),
              csr_pkg::phys_tag_t'($urandom_range(0, 255)));
    end
    run_csr("op_unimpl", csr_pkg::CSR_RW, 12'h7c0, 1'b0, '0, 8'd5);
  endtask

  task automatic test_full_station();
    csr_pkg::phys_tag_t tag;
    csr_pkg::phys_tag_t rds   [DEPTH];
    csr_pkg::inst_num_t inums [DEPTH];
    csr_pkg::word_t     old;
    tag = csr_pkg::phys_tag_t'($urandom_range(128, 255));
    for (int i = 0; i < DEPTH; i++) begin
      check_value("full_station", "rs_full", 0, rs_full);
      rds[i] = csr_pkg::phys_tag_t'($urandom_range(0, 127));
      send(csr_pkg::CSR_RS, csr_pkg::CSR_MSCRATCH, 1'b0, '0, tag, 1'b0, rds[i], inums[i]);
    end
    check_value("full_station", "rs_full", 1, rs_full);
    pulse_source(1, tag);
    check_value("full_station", "rs_full", 1, rs_full);
    step();
    check_value("full_station", "rs_full", 0, rs_full);
    step();
    for (int i = 0; i < DEPTH; i++) begin
      model_access(csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_RS, prf_mem[tag], old);
      check_value("full_station", "csr_done", 1, csr_done);
      check_value("full_station", "done_tag", rds[i], done_tag);
      check_value("full_station", "done_inst_num", inums[i], done_inst_num);
      check_value("full_station", "done_value", old, done_value);
      step();
    end
    expect_idle("full_station", 2);
  endtask

  task automatic test_flush_trap();
    csr_pkg::phys_tag_t tag;
    csr_pkg::inst_num_t inum;
    csr_pkg::word_t     mst;
    tag = csr_pkg::phys_tag_t'($urandom_range(128, 255));
    send(csr_pkg::CSR_RW, csr_pkg::CSR_MSCRATCH, 1'b0, '0, tag, 1'b0, 8'd1, inum);
    send(csr_pkg::CSR_RW, csr_pkg::CSR_MEPC, 1'b0, '0, tag, 1'b0, 8'd2, inum);
    flush = 1'b1;
    step();
    flush = 1'b0;
    pulse_source(0, tag);
    expect_idle("flush_pending", 6);
    // Flush hits an instruction sitting in the issue register.
    send(csr_pkg::CSR_RW, csr_pkg::CSR_MSCRATCH, 1'b0, '0, 8'd9, 1'b1, 8'd3, inum);
    step();
    flush = 1'b1;
    step();
    flush = 1'b0;
    expect_idle("flush_issued", 4);
    run_csr("flush_issued", csr_pkg::CSR_RS, csr_pkg::CSR_MSCRATCH, 1'b1, '0, '0);
    run_csr("trap", csr_pkg::CSR_RW, csr_pkg::CSR_MTVEC, 1'b0, '0, 8'd77);
    run_csr("trap", csr_pkg::CSR_RW, csr_pkg::CSR_MSTATUS, 1'b1, 32'h8, '0);
    trap       = 1'b1;
    trap_pc    = $urandom();
    trap_cause = csr_pkg::word_t'($urandom_range(0, 15));
    step();
    trap       = 1'b0;
    mst        = ref_csr[0];
    mst[csr_pkg::MSTATUS_MPIE] = mst[csr_pkg::MSTATUS_MIE];
    mst[csr_pkg::MSTATUS_MIE]  = 1'b0;
    ref_csr[0] = mst;
    ref_csr[3] = trap_pc;
    ref_csr[4] = trap_cause;
    check_value("trap", "epc", trap_pc, epc);
    check_value("trap", "trap_vector", ref_csr[1], trap_vector);
    run_csr("trap", csr_pkg::CSR_RS, csr_pkg::CSR_MEPC, 1'b1, '0, '0);
    run_csr("trap", csr_pkg::CSR_RS, csr_pkg::CSR_MCAUSE, 1'b1, '0, '0);
    run_csr("trap", csr_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 1'b1, '0, '0);
    mret = 1'b1;
    step();
    mret = 1'b0;
    mst  = ref_csr[0];
    mst[csr_pkg::MSTATUS_MIE]  = mst[csr_pkg::MSTATUS_MPIE];
    mst[csr_pkg::MSTATUS_MPIE] = 1'b1;
    ref_csr[0] = mst;
    run_csr("mret", csr_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 1'b1, '0, '0);
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    void'($urandom(41));
    clk        = 1'b0;
    arst_n     = 1'b0;
    dispatch   = 1'b0;
    inst_num   = '0;
    rd_tag     = '0;
    csr_op     = csr_pkg::CSR_RW;
    csr_addr   = '0;
    use_imm    = 1'b0;
    imm        = '0;
    src_tag    = '0;
    src_ready  = 1'b0;
    bc_done    = '0;
    bc_tags    = '{default: '0};
    flush      = 1'b0;
    trap       = 1'b0;
    mret       = 1'b0;
    trap_pc    = '0;
    trap_cause = '0;
    errors     = 0;
    next_inum  = 32'd1;
    ref_csr    = '{default: '0};
    for (int i = 0; i < 256; i++) prf_mem[i] = $urandom();
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_value("reset", "rs_full", 0, rs_full);
    check_value("reset", "csr_done", 0, csr_done);
    check_value("reset", "epc", 0, epc);
    check_value("reset", "trap_vector", 0, trap_vector);
    step();
    test_ready_dispatch();
    test_wakeup();
    test_op_variants();
    test_full_station();
    test_flush_trap();
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- csr_issue_top.f
rtl/csr_pkg.sv
rtl/csr_wakeup.sv
rtl/csr_rs.sv
rtl/csr_unit.sv
rtl/csr_issue_top.sv
verif/csr_issue_tb.sv
